//--- source/synapse_pkg.sv
`default_nettype none

package synapse_pkg;

  //////////////////// population
  localparam int N_SYNAPSES  = 128;                  // synapses visited per sweep
  localparam int DECAY_SHIFT = 7;                    // weight decay is w/128

  //////////////////// random source
  localparam logic [31:0] LFSR_SEED = 32'hcf96_016a; // reset value, never zero
  localparam logic [31:0] LFSR_TAPS = 32'h8020_0003; // x^32+x^22+x^2+x+1, galois form

  typedef logic [$clog2(N_SYNAPSES)-1:0] index_t;    // synapse address
  typedef logic signed [31:0]            current_t;  // synaptic current, x1024
  typedef logic        [31:0]            weight_t;   // synaptic weight, unsigned
  typedef logic        [31:0]            history_t;  // spike history, newest in bit 0
  typedef logic signed [38:0]            total_t;    // sum of 128 currents
  typedef logic        [31:0]            rand_t;     // lfsr draw and decay probability

  // one RAM word per synapse
  typedef struct packed {
    current_t current;                               // decaying synaptic current
    weight_t  weight;                                // plastic weight
    history_t pre_history;                           // presynaptic spikes, one bit per sweep
    history_t post_history;                          // postsynaptic spikes, one bit per sweep
  } synapse_rec_t;

  // two cycles per synapse slot
  typedef enum logic {
    READ,                                            // address goes to the RAM
    WRITE                                            // update and write back
  } sweep_state_t;

  // sweep result, valid from the o_sweep_done pulse on
  typedef struct packed {
    total_t   total_current;                         // sum over the whole population
    weight_t  last_weight;                           // new weight of slot 127
    current_t last_current;                          // new current of slot 127
  } sweep_out_t;

endpackage

`default_nettype wire

//--- source/neuron_pkg.sv
`default_nettype none

package neuron_pkg;

  //////////////////// neuron constants
  localparam int LEAK_SHIFT  = 3;                    // membrane keeps 7/8 per sweep
  localparam int INPUT_SHIFT = 7;                    // summed current scaled down by 128

  typedef logic signed [39:0] membrane_t;            // membrane potential

  // neuron state seen by the outside and by the population
  typedef struct packed {
    membrane_t membrane;                             // potential after the last update
    logic      spike;                                // set on the sweep that fired
  } neuron_out_t;

endpackage

`default_nettype wire

//--- source/synapse_state_ram.sv
`timescale 1ns/10ps
`default_nettype none

module synapse_state_ram (
  input  wire                        clk,
  input  wire synapse_pkg::index_t   i_addr,    // slot address, shared by read and write
  input  wire                        i_we,      // write the record at i_addr
  input  wire synapse_pkg::synapse_rec_t i_wdata,
  output synapse_pkg::synapse_rec_t  o_rdata    // record of i_addr, one cycle later
);

  //////////////////// storage
  synapse_pkg::synapse_rec_t mem [synapse_pkg::N_SYNAPSES];  // one word per synapse

  // single port, registered read
  // read during write returns the old word
  always_ff @(posedge clk) begin
    if (i_we) begin
      mem[i_addr] <= i_wdata;                    // write back from the WRITE phase
    end
    o_rdata <= mem[i_addr];                      // data lands in the following cycle
  end

endmodule

`default_nettype wire

//--- source/decay_lfsr.sv
`timescale 1ns/10ps
`default_nettype none

module decay_lfsr (
  input  wire                 clk,
  input  wire                 reset,
  input  wire                 i_step,     // advance once, one strobe per synapse slot
  output synapse_pkg::rand_t  o_value     // current draw for the decay compare
);

  synapse_pkg::rand_t next_value;         // value after one shift

  //////////////////// galois step
  // shift right and fold the taps in when a one drops out
  always_comb begin
    next_value = o_value >> 1;
    if (o_value[0]) begin
      next_value = next_value ^ synapse_pkg::LFSR_TAPS;
    end
  end

  // seed is nonzero, so the register never locks at zero
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      o_value <= synapse_pkg::LFSR_SEED;
    end else if (i_step) begin
      o_value <= next_value;              // hold between strobes
    end
  end

endmodule

`default_nettype wire

//--- source/synapse_population.sv
`timescale 1ns/10ps
`default_nettype none

module synapse_population (
  input  wire                            clk,
  input  wire                            reset,
  input  wire                            i_pre_spike,    // shared presynaptic level
  input  wire                            i_post_spike,   // neuron spike fed back
  input  wire synapse_pkg::weight_t      i_base_weight,  // weight written on the first pass
  input  wire synapse_pkg::weight_t      i_ltp,          // potentiation step
  input  wire synapse_pkg::weight_t      i_ltd,          // depression step
  input  wire synapse_pkg::rand_t        i_decay_prob,   // decay when draw <= this
  input  wire synapse_pkg::rand_t        i_rand,         // lfsr draw
  output logic                           o_rand_step,    // advance the lfsr
  output synapse_pkg::index_t            o_addr,         // RAM address
  output logic                           o_we,           // RAM write enable
  output synapse_pkg::synapse_rec_t      o_wdata,        // updated record
  input  wire synapse_pkg::synapse_rec_t i_rdata,        // record read in READ
  output synapse_pkg::sweep_out_t        o_sweep,        // sweep result
  output logic                           o_sweep_done    // one cycle per sweep
);

  localparam int HW = $bits(synapse_pkg::history_t);  // history length

  //////////////////// control state
  synapse_pkg::sweep_state_t state;      // slot phase
  synapse_pkg::index_t       slot;       // synapse being visited
  logic                      first_pass; // set until every word has been written once
  logic                      last_slot;  // slot 127
  logic                      first_slot; // slot 0

  //////////////////// sampled spikes
  logic pre_q;                           // pre spike held for the sweep
  logic post_q;                          // post spike held for the sweep

  //////////////////// datapath
  synapse_pkg::synapse_rec_t old_rec;    // record as read
  synapse_pkg::synapse_rec_t new_rec;    // record to write back
  synapse_pkg::current_t     cur_leak;   // 7/8 of the old current
  synapse_pkg::current_t     cur_impulse;// weight added on a pre spike
  synapse_pkg::weight_t      ltp_term;
  synapse_pkg::weight_t      ltd_term;
  synapse_pkg::weight_t      decay_term;
  logic signed [33:0]        weight_sum; // two guard bits for the signed sum
  logic                      decay_hit;  // random draw chose decay
  synapse_pkg::total_t       acc;        // running sum of new currents

  assign last_slot  = (slot == synapse_pkg::index_t'(synapse_pkg::N_SYNAPSES - 1));
  assign first_slot = (slot == '0);

  assign o_addr      = slot;                            // same address for READ and WRITE
  assign o_we        = (state == synapse_pkg::WRITE);   // write in every WRITE
  assign o_rand_step = (state == synapse_pkg::WRITE);   // one draw per slot
  assign o_wdata     = new_rec;
  assign old_rec     = i_rdata;

  // per-synapse update, valid in WRITE when the RAM data is there
  always_comb begin
    cur_leak    = (old_rec.current >>> 1) + (old_rec.current >>> 2) +
                  (old_rec.current >>> 3);              // 1/2 + 1/4 + 1/8
    cur_impulse = pre_q ? synapse_pkg::current_t'(old_rec.weight) : '0;

    ltp_term   = (post_q && (old_rec.pre_history != '0)) ? i_ltp : '0;   // post after pre
    ltd_term   = (pre_q && (old_rec.post_history != '0)) ? i_ltd : '0;   // pre after post
    decay_hit  = (i_rand <= i_decay_prob);              // prob 0 never, all ones always
    decay_term = decay_hit ? (old_rec.weight >> synapse_pkg::DECAY_SHIFT) : '0;

    weight_sum = $signed({2'b00, old_rec.weight}) + $signed({2'b00, ltp_term}) -
                 $signed({2'b00, ltd_term}) - $signed({2'b00, decay_term});

    if (first_pass) begin
      new_rec.current      = '0;                        // fresh synapse
      new_rec.weight       = i_base_weight;
      new_rec.pre_history  = '0;
      new_rec.post_history = '0;
    end else begin
      new_rec.current      = cur_leak + cur_impulse;
      new_rec.weight       = (weight_sum < 0) ? '0 : weight_sum[31:0];  // floor at zero
      new_rec.pre_history  = {old_rec.pre_history[HW-2:0], pre_q};
      new_rec.post_history = {old_rec.post_history[HW-2:0], post_q};
    end
  end

  // slot machine and sweep counter
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      state        <= synapse_pkg::READ;
      slot         <= '0;
      first_pass   <= 1'b1;
      o_sweep_done <= 1'b0;
    end else begin
      o_sweep_done <= 1'b0;                             // pulse by default low
      case (state)
        synapse_pkg::READ: begin
          state <= synapse_pkg::WRITE;
        end
        synapse_pkg::WRITE: begin
          state <= synapse_pkg::READ;
          slot  <= slot + 1'b1;                         // wraps 127 -> 0
          if (last_slot) begin
            first_pass   <= 1'b0;                       // all words now initialised
            o_sweep_done <= 1'b1;                       // next cycle is slot 0 READ
          end
        end
        default: begin
          state <= synapse_pkg::READ;
        end
      endcase
    end
  end

  // spike sampling and current summing
  always_ff @(posedge clk) begin
    if ((state == synapse_pkg::READ) && first_slot) begin
      pre_q  <= i_pre_spike;                            // one level for the whole sweep
      post_q <= i_post_spike;
    end
    if (state == synapse_pkg::WRITE) begin
      if (first_slot) begin
        acc <= synapse_pkg::total_t'(new_rec.current);  // restart the sum
      end else begin
        acc <= acc + synapse_pkg::total_t'(new_rec.current);
      end
      if (last_slot) begin
        o_sweep.total_current <= acc + synapse_pkg::total_t'(new_rec.current);
        o_sweep.last_weight   <= new_rec.weight;
        o_sweep.last_current  <= new_rec.current;
      end
    end
  end

endmodule

`default_nettype wire

//--- source/lif_neuron.sv
`timescale 1ns/10ps
`default_nettype none

module lif_neuron (
  input  wire                          clk,
  input  wire                          reset,
  input  wire synapse_pkg::sweep_out_t i_sweep,       // summed input of the sweep
  input  wire                          i_sweep_done,  // update strobe
  input  wire neuron_pkg::membrane_t   i_threshold,   // firing level
  output neuron_pkg::neuron_out_t      o_neuron,      // membrane and spike level
  output logic                         o_post_spike   // one cycle per firing
);

  //////////////////// integrate
  neuron_pkg::membrane_t leaked;      // membrane after the 7/8 leak
  neuron_pkg::membrane_t drive;       // scaled input current
  neuron_pkg::membrane_t sum;         // candidate membrane
  logic                  fire;        // threshold reached

  always_comb begin
    leaked = o_neuron.membrane - (o_neuron.membrane >>> neuron_pkg::LEAK_SHIFT);
    drive  = neuron_pkg::membrane_t'(i_sweep.total_current >>> neuron_pkg::INPUT_SHIFT);
    sum    = leaked + drive;
    fire   = (sum >= i_threshold);
  end

  //////////////////// update
  // one update per sweep, held in between
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      o_neuron     <= '0;             // resting membrane, no spike
      o_post_spike <= 1'b0;
    end else begin
      o_post_spike <= 1'b0;
      if (i_sweep_done) begin
        if (fire) begin
          o_neuron.membrane <= '0;    // reset after firing
          o_neuron.spike    <= 1'b1;
          o_post_spike      <= 1'b1;
        end else begin
          o_neuron.membrane <= sum;
          o_neuron.spike    <= 1'b0;
        end
      end
    end
  end

endmodule

`default_nettype wire

//--- source/snn_core.sv
`timescale 1ns/10ps
`default_nettype none

module snn_core (
  input  wire                          clk,
  input  wire                          reset,
  input  wire                          i_pre_spike,    // shared presynaptic level
  input  wire synapse_pkg::weight_t    i_base_weight,
  input  wire synapse_pkg::weight_t    i_ltp,
  input  wire synapse_pkg::weight_t    i_ltd,
  input  wire synapse_pkg::rand_t      i_decay_prob,
  input  wire neuron_pkg::membrane_t   i_threshold,
  output synapse_pkg::sweep_out_t      o_sweep,
  output logic                         o_sweep_done,
  output neuron_pkg::neuron_out_t      o_neuron,
  output logic                         o_post_spike
);

  //////////////////// ram side
  synapse_pkg::index_t       ram_addr;
  logic                      ram_we;
  synapse_pkg::synapse_rec_t ram_wdata;
  synapse_pkg::synapse_rec_t ram_rdata;

  //////////////////// random source
  synapse_pkg::rand_t rand_value;
  logic               rand_step;

  synapse_population pop0 (
    .clk          (clk),
    .reset        (reset),
    .i_pre_spike  (i_pre_spike),
    .i_post_spike (o_neuron.spike),   // neuron output fed back as post spike
    .i_base_weight(i_base_weight),
    .i_ltp        (i_ltp),
    .i_ltd        (i_ltd),
    .i_decay_prob (i_decay_prob),
    .i_rand       (rand_value),
    .o_rand_step  (rand_step),
    .o_addr       (ram_addr),
    .o_we         (ram_we),
    .o_wdata      (ram_wdata),
    .i_rdata      (ram_rdata),
    .o_sweep      (o_sweep),
    .o_sweep_done (o_sweep_done)
  );

  synapse_state_ram ram0 (
    .clk    (clk),
    .i_addr (ram_addr),
    .i_we   (ram_we),
    .i_wdata(ram_wdata),
    .o_rdata(ram_rdata)
  );

  decay_lfsr lfsr0 (
    .clk    (clk),
    .reset  (reset),
    .i_step (rand_step),
    .o_value(rand_value)
  );

  lif_neuron neuron0 (
    .clk         (clk),
    .reset       (reset),
    .i_sweep     (o_sweep),
    .i_sweep_done(o_sweep_done),
    .i_threshold (i_threshold),
    .o_neuron    (o_neuron),
    .o_post_spike(o_post_spike)
  );

endmodule

`default_nettype wire

//--- test/snn_core_properties.sv
`timescale 1ns/10ps
`default_nettype none

module snn_core_properties (
  input wire clk,
  input wire reset,
  input wire o_sweep_done,  // end of sweep pulse
  input wire o_post_spike,  // neuron firing pulse
  input wire ram_we         // RAM write enable of the WRITE phase
);

  int n_failed = 0;         // assertion failures so far

  //////////////////// sweep timing
  // single cycle pulse and the next one 256 cycles later
  a_sweep_period: assert property (@(posedge clk) disable iff (reset)
    o_sweep_done |=> (!o_sweep_done)[*255] ##1 o_sweep_done)
    else begin
      $error("sweep done pulse not repeating every 256 cycles");
      n_failed++;
    end

  //////////////////// neuron timing
  a_post_after_done: assert property (@(posedge clk) disable iff (reset)
    o_post_spike |-> $past(o_sweep_done))
    else begin
      $error("post spike outside the cycle after sweep done");
      n_failed++;
    end

  //////////////////// slot phases
  // READ and WRITE alternate so the write enable toggles every cycle
  a_we_alternates: assert property (@(posedge clk) disable iff (reset)
    !$past(reset) |-> (ram_we != $past(ram_we)))
    else begin
      $error("RAM write enable does not alternate");
      n_failed++;
    end

endmodule

bind snn_core snn_core_properties props0 (
  .clk         (clk),
  .reset       (reset),
  .o_sweep_done(o_sweep_done),
  .o_post_spike(o_post_spike),
  .ram_we      (ram_we)
);

`default_nettype wire

//--- test/snn_core_tb.sv
`timescale 1ns/10ps
`default_nettype none

module snn_core_tb;

  localparam int    N_ROWS  = 12;
  localparam int    TIMEOUT = 400;                   // cycles allowed per sweep
  localparam longint BASE_W = 4096;                  // weight after the first pass

  typedef struct packed {
    logic                  pre;                      // presynaptic level of the sweep
    synapse_pkg::weight_t  ltp;
    synapse_pkg::weight_t  ltd;
    synapse_pkg::rand_t    decay_prob;               // 0 or all ones
    neuron_pkg::membrane_t threshold;
    logic                  exp_post;                 // expected firing after the sweep
  } row_t;

  logic                      clk;
  logic                      reset;
  logic                      i_pre_spike;
  synapse_pkg::weight_t      i_base_weight;
  synapse_pkg::weight_t      i_ltp;
  synapse_pkg::weight_t      i_ltd;
  synapse_pkg::rand_t        i_decay_prob;
  neuron_pkg::membrane_t     i_threshold;
  synapse_pkg::sweep_out_t   o_sweep;
  logic                      o_sweep_done;
  neuron_pkg::neuron_out_t   o_neuron;
  logic                      o_post_spike;

  row_t   rows [N_ROWS];                             // stimulus table
  int     errors;
  longint m_cur;                                     // model current of one synapse
  longint m_w;                                       // model weight
  logic [31:0] m_preh;
  logic [31:0] m_posth;
  longint m_total;                                   // model sum over 128 synapses
  longint m_mem;                                     // model membrane
  logic   m_spike [N_ROWS];                          // model spike after each update

  snn_core dut0 (
    .clk(clk), .reset(reset), .i_pre_spike(i_pre_spike), .i_base_weight(i_base_weight),
    .i_ltp(i_ltp), .i_ltd(i_ltd), .i_decay_prob(i_decay_prob), .i_threshold(i_threshold),
    .o_sweep(o_sweep), .o_sweep_done(o_sweep_done), .o_neuron(o_neuron),
    .o_post_spike(o_post_spike)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;                          // 20 ns period
  end

  //////////////////// table
  task automatic fill_table();
    //          pre  ltp  ltd   decay         thr      post
    rows[0]  = {1'b0, 32'd0,   32'd0,    32'h0,        40'sd1000,    1'b0};  // first pass
    rows[1]  = {1'b1, 32'd0,   32'd0,    32'h0,        40'sd1000000, 1'b0};
    rows[2]  = {1'b1, 32'd0,   32'd0,    32'h0,        40'sd10000,   1'b1};  // fires
    rows[3]  = {1'b0, 32'd0,   32'd0,    32'h0,        40'sd1000000, 1'b0};  // leak only
    rows[4]  = {1'b0, 32'd100, 32'd0,    32'h0,        40'sd1000000, 1'b0};  // ltp
    rows[5]  = {1'b1, 32'd0,   32'd300,  32'h0,        40'sd1000000, 1'b0};  // ltd
    rows[6]  = {1'b0, 32'd0,   32'd0,    32'hffff_ffff, 40'sd1000000, 1'b0}; // decay
    rows[7]  = {1'b0, 32'd0,   32'd0,    32'hffff_ffff, 40'sd1000000, 1'b0};
    rows[8]  = {1'b0, 32'd0,   32'd0,    32'h0,        40'sd1000000, 1'b0};  // no decay
    rows[9]  = {1'b1, 32'd0,   32'd5000, 32'h0,        40'sd30000,   1'b1};  // clamp and fire
    rows[10] = {1'b0, 32'd0,   32'd0,    32'h0,        40'sd1000000, 1'b0};
    rows[11] = {1'b0, 32'd200, 32'd0,    32'h0,        40'sd1000000, 1'b0};  // ltp from zero
  endtask

  //////////////////// reference model
  // all synapses see the same inputs and share one model
  task automatic model_sweep(input int k);
    logic   p;
    logic   q;
    longint w_new;
    p = rows[k].pre;
    q = (k >= 2) ? m_spike[k-2] : 1'b0;              // feedback reaches the sweep after next
    if (k == 0) begin
      m_cur   = 0;
      m_w     = BASE_W;
      m_preh  = '0;
      m_posth = '0;
    end else begin
      w_new = m_w;
      if (q && m_preh != 0) w_new = w_new + rows[k].ltp;
      if (p && m_posth != 0) w_new = w_new - rows[k].ltd;
      if (rows[k].decay_prob == 32'hffff_ffff) w_new = w_new - (m_w >>> 7);
      if (w_new < 0) w_new = 0;                      // floor at zero
      m_cur   = (m_cur >>> 1) + (m_cur >>> 2) + (m_cur >>> 3) + (p ? m_w : 0);
      m_w     = w_new;
      m_preh  = {m_preh[30:0], p};
      m_posth = {m_posth[30:0], q};
    end
    m_total = m_cur * 128;
  endtask

  task automatic model_neuron(input int k);
    longint sum;
    sum = m_mem - (m_mem >>> 3) + (m_total >>> 7);   // leak plus scaled input
    if (sum >= longint'(rows[k].threshold)) begin
      m_mem      = 0;
      m_spike[k] = 1'b1;
    end else begin
      m_mem      = sum;
      m_spike[k] = 1'b0;
    end
  endtask

  //////////////////// checks
  task automatic compare(input string name, input longint got, input longint exp);
    if (got !== exp) begin
      errors++;
      $display("** Error at %0t: %s = %0d, expected %0d", $time, name, got, exp);
    end
  endtask

  task automatic wait_sweep_done();
    int cycles;
    cycles = 0;
    @(negedge clk);
    while (!o_sweep_done && cycles < TIMEOUT) begin
      @(negedge clk);
      cycles++;
    end
    if (!o_sweep_done) begin
      $display("timeout, no sweep done pulse within %0d cycles", TIMEOUT);
      $display("** FAIL **");
      $finish;
    end
  endtask

  task automatic check_sweep(input longint tot, input longint w, input longint cur);
    compare("o_sweep.total_current", longint'(o_sweep.total_current), tot);
    compare("o_sweep.last_weight", longint'(o_sweep.last_weight), w);
    compare("o_sweep.last_current", longint'(o_sweep.last_current), cur);
  endtask

  //////////////////// main sequence
  initial begin
    errors = 0;
    m_mem  = 0;
    fill_table();
    reset         = 1'b1;
    i_base_weight = synapse_pkg::weight_t'(BASE_W);
    i_pre_spike   = rows[0].pre;
    i_ltp         = rows[0].ltp;
    i_ltd         = rows[0].ltd;
    i_decay_prob  = rows[0].decay_prob;
    i_threshold   = rows[0].threshold;
    repeat (4) @(posedge clk);
    reset <= 1'b0;
    @(posedge clk);                                  // sweep 0 samples its spikes here
    i_pre_spike <= rows[1].pre;                      // pre leads the other columns by one row
    for (int k = 0; k < N_ROWS; k++) begin
      wait_sweep_done();
      model_sweep(k);
      check_sweep(m_total, m_w, m_cur);
      @(posedge clk);                                // neuron update and next sample edge
      if (k + 1 < N_ROWS) begin
        i_ltp        <= rows[k+1].ltp;
        i_ltd        <= rows[k+1].ltd;
        i_decay_prob <= rows[k+1].decay_prob;
        i_threshold  <= rows[k+1].threshold;
      end
      if (k + 2 < N_ROWS) i_pre_spike <= rows[k+2].pre;
      model_neuron(k);
      @(negedge clk);
      compare("o_neuron.membrane", longint'(o_neuron.membrane), m_mem);
      compare("o_neuron.spike", longint'(o_neuron.spike), longint'(m_spike[k]));
      compare("o_post_spike", longint'(o_post_spike), longint'(rows[k].exp_post));
    end

    // reset in the middle of a sweep brings back the first pass
    repeat (100) @(posedge clk);
    reset <= 1'b1;
    repeat (4) @(posedge clk);
    reset <= 1'b0;
    wait_sweep_done();
    check_sweep(0, BASE_W, 0);
    @(posedge clk);
    @(negedge clk);
    compare("o_neuron.membrane", longint'(o_neuron.membrane), 0);
    compare("o_post_spike", longint'(o_post_spike), 0);

    $display("errors: %0d  assertion failures: %0d", errors, dut0.props0.n_failed);
    if (errors == 0 && dut0.props0.n_failed == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- flist.f
source/synapse_pkg.sv
source/neuron_pkg.sv
source/synapse_state_ram.sv
source/decay_lfsr.sv
source/synapse_population.sv
source/lif_neuron.sv
source/snn_core.sv
test/snn_core_properties.sv
test/snn_core_tb.sv
